// ==== vlog.f ====
design/dma_pkg.sv
design/sg_queue.sv
design/dma_port_engine.sv
design/dma_ctrl.sv
design/dma_top.sv
testbench/dma_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA testbench with Verilator; exit status reports pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module dma_tb

./obj_dir/Vdma_tb

// ==== testbench/dma_tb.sv ====
/*
	Testbench for the scatter-gather DMA. Runs a job table through dma_top against
	two word memories with random ack delays, then checks memory contents and status.
*/

`timescale 1ns/1ps

module dma_tb;

	typedef struct packed {
		logic direction;
		dma_pkg::addr_t fpga_addr;
		logic irq_en;
		logic [3:0] first_desc;
		logic [1:0] num_desc;
		logic [3:0] exp_resp;
	} job_t;

	localparam int num_jobs = 4;
	localparam dma_pkg::addr_t fpga_err_addr = 20'h000c2;
	localparam dma_pkg::addr_t host_err_addr = 20'h000a5;

	logic clk = 1'b0;
	logic rst_n;
	logic desc_push;
	dma_pkg::sg_desc_t desc_in;
	logic desc_full;
	logic trigger;
	logic direction;
	dma_pkg::addr_t fpga_addr;
	logic irq_en;
	logic irq_clr;
	logic irq;
	logic busy;
	logic [3:0] response;
	dma_pkg::mem_req_t fpga_req;
	dma_pkg::mem_req_t host_req;
	dma_pkg::mem_rsp_t fpga_rsp = '0;
	dma_pkg::mem_rsp_t host_rsp = '0;

	dma_pkg::data_t fpga_mem [256];
	dma_pkg::data_t host_mem [256];
	dma_pkg::data_t exp_fpga [256];
	dma_pkg::data_t exp_host [256];
	logic [31:0] rng_state = 32'h0ae94eaa;
	int fpga_wait = -1;
	int host_wait = -1;

	job_t jobs [num_jobs];
	dma_pkg::sg_desc_t desc_tab [16];

	dma_top dma_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.desc_push(desc_push),
		.desc_in(desc_in),
		.desc_full(desc_full),
		.trigger(trigger),
		.direction(direction),
		.fpga_addr(fpga_addr),
		.irq_en(irq_en),
		.irq_clr(irq_clr),
		.irq(irq),
		.busy(busy),
		.response(response),
		.fpga_req(fpga_req),
		.fpga_rsp(fpga_rsp),
		.host_req(host_req),
		.host_rsp(host_rsp)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic dma_pkg::data_t fill_word(input logic fpga_side, input logic [7:0] a);
		return fpga_side ? {8'hf0, a, ~a, 8'h3c} : {8'h40, ~a, 8'ha5, a};
	endfunction

	// Word memories that ack each request after 0 to 3 idle cycles
	always @(posedge clk) begin
		#1;
		fpga_rsp = '0;
		host_rsp = '0;
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) begin
				fpga_mem[i[7:0]] = fill_word(1'b1, i[7:0]);
				host_mem[i[7:0]] = fill_word(1'b0, i[7:0]);
			end
			fpga_wait = -1;
			host_wait = -1;
		end else begin
			if (fpga_req.req) begin
				if (fpga_wait < 0) begin
					rng_state = xorshift32(rng_state);
					fpga_wait = int'(rng_state[1:0]);
				end
				if (fpga_wait == 0) begin
					fpga_rsp.ack = 1'b1;
					fpga_rsp.err = (fpga_req.addr == fpga_err_addr);
					if (fpga_req.we) begin
						fpga_mem[fpga_req.addr[7:0]] = fpga_req.wdata;
					end else begin
						fpga_rsp.rdata = fpga_mem[fpga_req.addr[7:0]];
					end
				end
				fpga_wait = fpga_wait - 1;
			end
			if (host_req.req) begin
				if (host_wait < 0) begin
					rng_state = xorshift32(rng_state);
					host_wait = int'(rng_state[1:0]);
				end
				if (host_wait == 0) begin
					host_rsp.ack = 1'b1;
					host_rsp.err = (host_req.addr == host_err_addr);
					if (host_req.we) begin
						host_mem[host_req.addr[7:0]] = host_req.wdata;
					end else begin
						host_rsp.rdata = host_mem[host_req.addr[7:0]];
					end
				end
				host_wait = host_wait - 1;
			end
		end
	end

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic stop_on_failure();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want) else begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, want);
			stop_on_failure();
		end
	endtask

	task automatic wait_job_end(input int limit);
		int cycles;
		cycles = 0;
		while (busy) begin
			tick();
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: busy did not fall within %0d cycles", limit);
				stop_on_failure();
			end
		end
	endtask

	initial begin
		int fa;
		dma_pkg::sg_desc_t d;
		rst_n = 1'b0;
		desc_push = 1'b0;
		desc_in = '0;
		trigger = 1'b0;
		direction = 1'b0;
		fpga_addr = '0;
		irq_en = 1'b0;
		irq_clr = 1'b0;

		// host_addr, length (words minus one)
		desc_tab[0] = '{20'h00020, 8'd3};
		desc_tab[1] = '{20'h00040, 8'd0};
		desc_tab[2] = '{20'h00060, 8'd6};
		desc_tab[3] = '{20'h00030, 8'd2};
		desc_tab[4] = '{20'h00050, 8'd4};
		desc_tab[5] = '{20'h000a3, 8'd3};
		desc_tab[6] = '{20'h00070, 8'd1};
		desc_tab[7] = '{20'h000b0, 8'd1};
		desc_tab[8] = '{20'h000b4, 8'd2};
		// direction, fpga_addr, irq_en, first_desc, num_desc, exp_resp
		jobs[0] = '{1'b1, 20'h00010, 1'b1, 4'd0, 2'd3, 4'h0};
		jobs[1] = '{1'b0, 20'h00080, 1'b0, 4'd3, 2'd2, 4'h0};
		jobs[2] = '{1'b1, 20'h00040, 1'b1, 4'd5, 2'd2, 4'h8};
		jobs[3] = '{1'b0, 20'h000c2, 1'b0, 4'd7, 2'd2, 4'h2};

		for (int i = 0; i < 256; i++) begin
			exp_fpga[i[7:0]] = fill_word(1'b1, i[7:0]);
			exp_host[i[7:0]] = fill_word(1'b0, i[7:0]);
		end

		repeat (4) @(posedge clk);
		#1;
		expect_equal("busy", 32'(busy), 32'h0);
		expect_equal("irq", 32'(irq), 32'h0);
		expect_equal("fpga_req.req", 32'(fpga_req.req), 32'h0);
		expect_equal("host_req.req", 32'(host_req.req), 32'h0);
		expect_equal("response", 32'(response), 32'h0);
		rst_n = 1'b1;
		tick();

		// Trigger with nothing queued
		trigger = 1'b1;
		tick();
		trigger = 1'b0;
		repeat (5) begin
			expect_equal("busy", 32'(busy), 32'h0);
			tick();
		end

		// Fill the queue up to SG_DEPTH entries
		desc_in = desc_tab[0];
		desc_push = 1'b1;
		for (int k = 0; k < dma_pkg::SG_DEPTH; k++) begin
			expect_equal("desc_full", 32'(desc_full), 32'h0);
			tick();
		end
		desc_push = 1'b0;
		expect_equal("desc_full", 32'(desc_full), 32'h1);

		// Reset again to empty the queue
		rst_n = 1'b0;
		repeat (4) tick();
		rst_n = 1'b1;
		tick();
		expect_equal("desc_full", 32'(desc_full), 32'h0);

		for (int j = 0; j < num_jobs; j++) begin
			fa = int'(jobs[j].fpga_addr);
			for (int k = 0; k < int'(jobs[j].num_desc); k++) begin
				d = desc_tab[4'(int'(jobs[j].first_desc) + k)];
				for (int w = 0; w <= int'(d.length); w++) begin
					if (jobs[j].direction) begin
						exp_fpga[8'(fa + w)] = exp_host[8'(int'(d.host_addr) + w)];
					end else begin
						exp_host[8'(int'(d.host_addr) + w)] = exp_fpga[8'(fa + w)];
					end
				end
				fa = fa + int'(d.length) + 1;
			end

			for (int k = 0; k < int'(jobs[j].num_desc); k++) begin
				desc_in = desc_tab[4'(int'(jobs[j].first_desc) + k)];
				desc_push = 1'b1;
				tick();
			end
			desc_push = 1'b0;
			direction = jobs[j].direction;
			fpga_addr = jobs[j].fpga_addr;
			irq_en = jobs[j].irq_en;
			trigger = 1'b1;
			tick();
			trigger = 1'b0;
			expect_equal("busy", 32'(busy), 32'h1);
			expect_equal("response", 32'(response), 32'h0);
			wait_job_end(4000);

			expect_equal("irq", 32'(irq), 32'(jobs[j].irq_en));
			expect_equal("response", 32'(response), 32'(jobs[j].exp_resp));
			for (int i = 0; i < 256; i++) begin
				expect_equal($sformatf("fpga_mem[%h]", i[7:0]), fpga_mem[i[7:0]],
					exp_fpga[i[7:0]]);
				expect_equal($sformatf("host_mem[%h]", i[7:0]), host_mem[i[7:0]],
					exp_host[i[7:0]]);
			end

			if (jobs[j].irq_en) begin
				irq_clr = 1'b1;
				tick();
				irq_clr = 1'b0;
			end else begin
				tick();
			end
			expect_equal("irq", 32'(irq), 32'h0);
			// Let the controller get back to IDLE
			tick();
			tick();
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== design/dma_top.sv ====
/*
	Scatter-gather DMA top level. Ties the descriptor queue, the job controller
	and the FPGA-side and host-side port engines together.
*/

`timescale 1ns/1ps

module dma_top (
	input logic clk,
	input logic rst_n,
	input logic desc_push,
	input dma_pkg::sg_desc_t desc_in,
	output logic desc_full,
	input logic trigger,
	input logic direction,
	input dma_pkg::addr_t fpga_addr,
	input logic irq_en,
	input logic irq_clr,
	output logic irq,
	output logic busy,
	output logic [3:0] response,
	output dma_pkg::mem_req_t fpga_req,
	input dma_pkg::mem_rsp_t fpga_rsp,
	output dma_pkg::mem_req_t host_req,
	input dma_pkg::mem_rsp_t host_rsp
);
	dma_pkg::occ_t occupancy;
	dma_pkg::sg_desc_t head_desc;
	logic desc_pop;

	logic io_start;
	logic io_write_fpga;
	dma_pkg::addr_t io_fpga_addr;
	dma_pkg::addr_t io_host_addr;
	dma_pkg::len_t io_count;

	logic fpga_busy;
	logic host_busy;
	dma_pkg::resp_t fpga_resp;
	dma_pkg::resp_t host_resp;

	// Word streams between the engines
	dma_pkg::data_t f2h_data;
	logic f2h_valid;
	logic f2h_ready;
	dma_pkg::data_t h2f_data;
	logic h2f_valid;
	logic h2f_ready;

	sg_queue sg_queue_i (
		.clk(clk),
		.rst_n(rst_n),
		.push(desc_push),
		.push_desc(desc_in),
		.pop(desc_pop),
		.head_desc(head_desc),
		.occupancy(occupancy),
		.full(desc_full)
	);

	dma_ctrl dma_ctrl_i (
		.clk(clk),
		.rst_n(rst_n),
		.trigger(trigger),
		.direction(direction),
		.fpga_addr(fpga_addr),
		.irq_en(irq_en),
		.irq_clr(irq_clr),
		.irq(irq),
		.busy(busy),
		.response(response),
		.occupancy(occupancy),
		.head_desc(head_desc),
		.desc_pop(desc_pop),
		.fpga_busy(fpga_busy),
		.host_busy(host_busy),
		.fpga_resp(fpga_resp),
		.host_resp(host_resp),
		.io_start(io_start),
		.io_write_fpga(io_write_fpga),
		.io_fpga_addr(io_fpga_addr),
		.io_host_addr(io_host_addr),
		.io_count(io_count)
	);

	dma_port_engine fpga_engine_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(io_start),
		.write_mode(io_write_fpga),
		.start_addr(io_fpga_addr),
		.word_count(io_count),
		.busy(fpga_busy),
		.response(fpga_resp),
		.mem_req(fpga_req),
		.mem_rsp(fpga_rsp),
		.snk_data(h2f_data),
		.snk_valid(h2f_valid),
		.snk_ready(h2f_ready),
		.src_data(f2h_data),
		.src_valid(f2h_valid),
		.src_ready(f2h_ready)
	);

	// Host side always runs the opposite direction
	dma_port_engine host_engine_i (
		.clk(clk),
		.rst_n(rst_n),
		.start(io_start),
		.write_mode(~io_write_fpga),
		.start_addr(io_host_addr),
		.word_count(io_count),
		.busy(host_busy),
		.response(host_resp),
		.mem_req(host_req),
		.mem_rsp(host_rsp),
		.snk_data(f2h_data),
		.snk_valid(f2h_valid),
		.snk_ready(f2h_ready),
		.src_data(h2f_data),
		.src_valid(h2f_valid),
		.src_ready(h2f_ready)
	);

endmodule

// ==== design/dma_ctrl.sv ====
/*
	Job controller. Pops descriptors one by one, starts both port engines per
	descriptor, folds their responses into sticky codes and signals job end.
*/

`timescale 1ns/1ps

module dma_ctrl (
	input logic clk,
	input logic rst_n,
	input logic trigger,
	input logic direction,
	input dma_pkg::addr_t fpga_addr,
	input logic irq_en,
	input logic irq_clr,
	output logic irq,
	output logic busy,
	output logic [3:0] response,
	input dma_pkg::occ_t occupancy,
	input dma_pkg::sg_desc_t head_desc,
	output logic desc_pop,
	input logic fpga_busy,
	input logic host_busy,
	input dma_pkg::resp_t fpga_resp,
	input dma_pkg::resp_t host_resp,
	output logic io_start,
	output logic io_write_fpga,
	output dma_pkg::addr_t io_fpga_addr,
	output dma_pkg::addr_t io_host_addr,
	output dma_pkg::len_t io_count
);
	typedef enum logic [1:0] {IDLE, FETCH, WAIT, DONE} state_t;

	state_t state;
	logic engines_done;

	// FETCH is only entered with a descriptor waiting
	assign desc_pop = (state == FETCH);

	// Engines see start one cycle late, so ignore busy during the pulse
	assign engines_done = !io_start && !fpga_busy && !host_busy;

	always_ff @(posedge clk) begin
		if (state == IDLE && trigger && occupancy != '0) begin
			io_fpga_addr <= fpga_addr;
		end else if (state == WAIT && engines_done) begin
			io_fpga_addr <= io_fpga_addr + dma_pkg::addr_t'(io_count) + 1'b1;
		end
		if (state == FETCH) begin
			io_host_addr <= head_desc.host_addr;
			io_count <= head_desc.length;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
			irq <= 1'b0;
			busy <= 1'b0;
			response <= 4'd0;
			io_start <= 1'b0;
			io_write_fpga <= 1'b0;
		end else begin
			io_start <= 1'b0;
			case (state)
				IDLE: begin
					if (trigger && occupancy != '0) begin
						busy <= 1'b1;
						response <= 4'd0;
						io_write_fpga <= direction;
						state <= FETCH;
					end
				end

				FETCH: begin
					io_start <= 1'b1;
					state <= WAIT;
				end

				WAIT: begin
					if (engines_done) begin
						if (response[3:2] != dma_pkg::RESP_SLVERR) begin
							response[3:2] <= host_resp;
						end
						if (response[1:0] != dma_pkg::RESP_SLVERR) begin
							response[1:0] <= fpga_resp;
						end
						if (occupancy != '0) begin
							state <= FETCH;
						end else begin
							busy <= 1'b0;
							irq <= irq_en;
							state <= DONE;
						end
					end
				end

				DONE: begin
					if (irq_clr) begin
						irq <= 1'b0;
					end
					if (!irq) begin
						state <= IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== design/dma_port_engine.sv ====
/*
	Word-port engine for one memory side. In read mode it fetches words into the
	output stream, in write mode it stores words taken from the input stream.
*/

`timescale 1ns/1ps

module dma_port_engine (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic write_mode,
	input dma_pkg::addr_t start_addr,
	input dma_pkg::len_t word_count,
	output logic busy,
	output dma_pkg::resp_t response,
	output dma_pkg::mem_req_t mem_req,
	input dma_pkg::mem_rsp_t mem_rsp,
	input dma_pkg::data_t snk_data,
	input logic snk_valid,
	output logic snk_ready,
	output dma_pkg::data_t src_data,
	output logic src_valid,
	input logic src_ready
);
	typedef enum logic [1:0] {idle, request, stream, finish} state_t;

	state_t state;
	logic mode_wr;
	logic err_seen;
	dma_pkg::addr_t addr_r;
	dma_pkg::len_t remaining;
	// Read word on its way out, or write word on its way to memory
	dma_pkg::data_t data_r;

	assign busy = (state != idle);

	assign mem_req.req = (state == request);
	assign mem_req.we = mode_wr;
	assign mem_req.addr = addr_r;
	assign mem_req.wdata = data_r;

	assign src_data = data_r;
	assign snk_ready = (state == stream) && mode_wr;

	always_ff @(posedge clk) begin
		if (state == request && mem_rsp.ack && !mode_wr) begin
			data_r <= mem_rsp.rdata;
		end else if (snk_valid && snk_ready) begin
			data_r <= snk_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			mode_wr <= 1'b0;
			err_seen <= 1'b0;
			addr_r <= '0;
			remaining <= '0;
			src_valid <= 1'b0;
			response <= dma_pkg::RESP_OKAY;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						mode_wr <= write_mode;
						addr_r <= start_addr;
						remaining <= word_count;
						err_seen <= 1'b0;
						response <= dma_pkg::RESP_OKAY;
						state <= write_mode ? stream : request;
					end
				end

				request: begin
					if (mem_rsp.ack) begin
						// Keep going after an error, only the code remembers it
						err_seen <= err_seen | mem_rsp.err;
						if (!mode_wr) begin
							src_valid <= 1'b1;
							state <= stream;
						end else if (remaining == '0) begin
							state <= finish;
						end else begin
							addr_r <= addr_r + 1'b1;
							remaining <= remaining - 1'b1;
							state <= stream;
						end
					end
				end

				stream: begin
					if (mode_wr) begin
						if (snk_valid) begin
							state <= request;
						end
					end else if (src_ready) begin
						src_valid <= 1'b0;
						if (remaining == '0) begin
							state <= finish;
						end else begin
							addr_r <= addr_r + 1'b1;
							remaining <= remaining - 1'b1;
							state <= request;
						end
					end
				end

				finish: begin
					response <= err_seen ? dma_pkg::RESP_SLVERR : dma_pkg::RESP_OKAY;
					state <= idle;
				end
			endcase
		end
	end

endmodule

// ==== design/sg_queue.sv ====
/*
	Descriptor FIFO between software and the DMA controller.
	Head entry is always visible; pop is a one-cycle strobe.
*/

`timescale 1ns/1ps

module sg_queue (
	input logic clk,
	input logic rst_n,
	input logic push,
	input dma_pkg::sg_desc_t push_desc,
	input logic pop,
	output dma_pkg::sg_desc_t head_desc,
	output dma_pkg::occ_t occupancy,
	output logic full
);
	dma_pkg::sg_desc_t mem [dma_pkg::SG_DEPTH];

	logic [dma_pkg::SG_PTR_W-1:0] wr_ptr;
	logic [dma_pkg::SG_PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (occupancy == dma_pkg::occ_t'(dma_pkg::SG_DEPTH));

	// Pushes into a full queue are lost
	assign do_push = push && !full;
	assign do_pop = pop && (occupancy != '0);

	assign head_desc = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_desc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupancy <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				occupancy <= occupancy + 1'b1;
			end else if (do_pop && !do_push) begin
				occupancy <= occupancy - 1'b1;
			end
		end
	end

endmodule

// ==== design/dma_pkg.sv ====
/*
	Shared widths, response codes and bus structs for the scatter-gather DMA.
	Referenced by scoped name from every design unit.
*/

package dma_pkg;

	// Word address on both memory sides
	typedef logic [19:0] addr_t;
	typedef logic [31:0] data_t;

	// Word count minus one
	typedef logic [7:0] len_t;

	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;

	localparam int SG_DEPTH = 16;
	localparam int SG_PTR_W = $clog2(SG_DEPTH);

	// Queue fill level, 0 to SG_DEPTH
	typedef logic [SG_PTR_W:0] occ_t;

	typedef struct packed {
		addr_t host_addr;
		len_t length;
	} sg_desc_t;

	// Engine to memory, held until ack
	typedef struct packed {
		logic req;
		logic we;
		addr_t addr;
		data_t wdata;
	} mem_req_t;

	// Memory to engine, err and rdata valid with ack
	typedef struct packed {
		logic ack;
		logic err;
		data_t rdata;
	} mem_rsp_t;

endpackage
